/* sim.f */
rv_pkg.sv
stage_if.sv
reg_file.sv
hazard_detect.sv
operand_forward.sv
issue_stage.sv
exec_pipe.sv
mini_pipe_top.sv
tb_mini_pipe.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_mini_pipe
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "TEST PASSED" || (echo "TEST FAILED"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_mini_pipe.sv */
`default_nettype none

module tb_mini_pipe;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DMEM_WORDS = 16;

    typedef struct {
        rv_pkg::uop_t uop;
        int           stall_cycles;
    } row_t;

    logic                              clk;
    logic                              rst;
    logic                              in_valid;
    rv_pkg::uop_t                      in_uop;
    logic                              in_ready;
    logic                              wb_valid;
    logic [rv_pkg::REG_ADDR_WIDTH-1:0] wb_rd;
    logic [rv_pkg::XLEN-1:0]           wb_data;

    row_t        rows[$];
    logic [4:0]  exp_rd_q[$];
    logic [63:0] exp_data_q[$];
    int          cycle_count;
    int          timeout_limit;

    mini_pipe_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dut_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_uop   (in_uop),
        .in_ready (in_ready),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic add_row(input rv_pkg::op_e op, input int rd, input int rs1, input int rs2,
                           input int imm, input int stall_cycles);
        row_t r;
        r.uop.op = op;
        r.uop.rd = 5'(rd);
        r.uop.rs1 = 5'(rs1);
        r.uop.rs2 = 5'(rs2);
        r.uop.imm = 12'(imm);
        r.stall_cycles = stall_cycles;
        rows.push_back(r);
    endtask

    // The last column is the number of cycles the entry waits in decode.
    // A dependent micro-op waits one cycle whenever its producer is still in EX
    task automatic build_table();
        add_row(rv_pkg::OP_ADDI, 1, 0, 0, 100, 0);
        add_row(rv_pkg::OP_ADDI, 2, 0, 0, -7, 0);
        add_row(rv_pkg::OP_ADDI, 3, 0, 0, 2047, 0);
        add_row(rv_pkg::OP_ADDI, 4, 0, 0, -2048, 0);
        add_row(rv_pkg::OP_ADDI, 6, 0, 0, 55, 0);
        add_row(rv_pkg::OP_ADDI, 7, 0, 0, 9, 0);
        add_row(rv_pkg::OP_ADD, 5, 1, 2, 0, 0);
        add_row(rv_pkg::OP_SUB, 8, 3, 4, 0, 0);
        add_row(rv_pkg::OP_SUB, 9, 1, 3, 0, 0);
        add_row(rv_pkg::OP_ADD, 10, 5, 6, 0, 0);
        add_row(rv_pkg::OP_SUB, 11, 10, 7, 0, 1);
        add_row(rv_pkg::OP_ADDI, 12, 10, 0, 3, 0);
        add_row(rv_pkg::OP_ADD, 13, 11, 12, 0, 1);
        add_row(rv_pkg::OP_ADDI, 14, 0, 0, 40, 0);
        add_row(rv_pkg::OP_ADDI, 15, 0, 0, 1, 0);
        add_row(rv_pkg::OP_ADD, 16, 14, 1, 0, 0);
        add_row(rv_pkg::OP_SUB, 17, 1, 15, 0, 0);
        // Two writes to x18 are in flight and the younger one must win
        add_row(rv_pkg::OP_ADDI, 18, 0, 0, 5, 0);
        add_row(rv_pkg::OP_ADDI, 18, 0, 0, 6, 0);
        add_row(rv_pkg::OP_ADDI, 20, 0, 0, 1, 0);
        add_row(rv_pkg::OP_ADD, 19, 18, 18, 0, 0);
        add_row(rv_pkg::OP_ADDI, 21, 0, 0, 16, 0);
        add_row(rv_pkg::OP_ADDI, 22, 0, 0, 0, 0);
        add_row(rv_pkg::OP_LOAD, 23, 21, 0, 8, 0);
        add_row(rv_pkg::OP_ADD, 24, 23, 1, 0, 1);
        add_row(rv_pkg::OP_LOAD, 25, 0, 0, 120, 0);
        add_row(rv_pkg::OP_LOAD, 26, 0, 0, 128, 0);
        add_row(rv_pkg::OP_LOAD, 27, 0, 0, -8, 0);
        add_row(rv_pkg::OP_LOAD, 28, 21, 0, 2000, 0);
        add_row(rv_pkg::OP_SUB, 29, 28, 25, 0, 1);
        add_row(rv_pkg::OP_ADDI, 0, 0, 0, 77, 0);
        add_row(rv_pkg::OP_ADD, 30, 0, 0, 0, 0);
        add_row(rv_pkg::OP_ADDI, 31, 0, 0, 1, 0);
        add_row(rv_pkg::OP_ADD, 1, 0, 30, 0, 0);
        add_row(rv_pkg::OP_SUB, 2, 1, 31, 0, 1);
    endtask

    function automatic logic [63:0] sign_extend(input logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    // Every byte of word i equals i
    function automatic logic [63:0] memory_word(input logic [63:0] addr);
        logic [63:0] idx;
        idx = (addr >> 3) % 64'(DMEM_WORDS);
        return {8{idx[7:0]}};
    endfunction

    // In-order model, one micro-op at a time
    task automatic run_model();
        logic [63:0]  regs [32];
        logic [63:0]  a;
        logic [63:0]  b;
        logic [63:0]  result;
        rv_pkg::uop_t u;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        foreach (rows[i]) begin
            u = rows[i].uop;
            a = regs[u.rs1];
            if ((u.op == rv_pkg::OP_ADD) || (u.op == rv_pkg::OP_SUB)) begin
                b = regs[u.rs2];
            end else begin
                b = sign_extend(u.imm);
            end
            case (u.op)
                rv_pkg::OP_SUB:  result = a - b;
                rv_pkg::OP_LOAD: result = memory_word(a + b);
                default:         result = a + b;
            endcase
            if (u.rd != '0) begin
                regs[u.rd] = result;
            end
            exp_rd_q.push_back(u.rd);
            exp_data_q.push_back(result);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("Writeback of x%0d seen with no micro-op outstanding", wb_rd);
                $display("Finished with errors");
                $fatal(1, "Unexpected writeback");
            end else begin
                check_value("wb_rd", 64'(wb_rd), 64'(exp_rd_q.pop_front()));
                check_value("wb_data", wb_data, exp_data_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout after %0d cycles: the pipeline stopped retiring, %0d results missing",
                     cycle_count, exp_rd_q.size());
            $display("Finished with errors");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        int   low_cycles;
        int   expected_low;
        logic accepted;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_uop = '0;
        cycle_count = 0;
        build_table();
        run_model();
        timeout_limit = rows.size() * 3 + 20;

        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        check_value("wb_valid", 64'(wb_valid), 64'd0);
        check_value("in_ready", 64'(in_ready), 64'd1);
        @(posedge clk);
        #5;

        foreach (rows[i]) begin
            in_valid = 1'b1;
            in_uop = rows[i].uop;
            low_cycles = 0;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                if (in_ready) begin
                    accepted = 1'b1;
                end else begin
                    low_cycles++;
                end
                @(posedge clk);
                #5;
            end
            // A low in_ready while offering this entry comes from the entry ahead in decode
            if (i == 0) begin
                expected_low = 0;
            end else begin
                expected_low = rows[i-1].stall_cycles;
            end
            check_value("in_ready_low_cycles", 64'(low_cycles), 64'(expected_low));
        end

        in_valid = 1'b0;
        in_uop = '0;
        low_cycles = 0;
        repeat (2) begin
            @(negedge clk);
            if (!in_ready) begin
                low_cycles++;
            end
        end
        check_value("in_ready_low_cycles", 64'(low_cycles),
                    64'(rows[rows.size()-1].stall_cycles));

        while (exp_rd_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        if (exp_rd_q.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "Results still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

/* mini_pipe_top.sv */
`default_nettype none

module mini_pipe_top #(
    parameter int DMEM_WORDS = 16
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              in_valid,
    input  wire rv_pkg::uop_t                      in_uop,
    output      logic                              in_ready,
    output      logic                              wb_valid,
    output      logic [rv_pkg::REG_ADDR_WIDTH-1:0] wb_rd,
    output      logic [rv_pkg::XLEN-1:0]           wb_data
);

    stage_if ex_bus ();
    stage_if mem_bus ();
    stage_if wb_bus ();

    logic                    dec_valid;
    rv_pkg::uop_t            dec_uop;
    logic                    stall;
    rv_pkg::fwd_sel_e        sel_a;
    rv_pkg::fwd_sel_e        sel_b;
    logic [rv_pkg::XLEN-1:0] rf_a;
    logic [rv_pkg::XLEN-1:0] rf_b;
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;

    reg_file rf_i (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (dec_uop.rs1),
        .raddr_b (dec_uop.rs2),
        .rdata_a (rf_a),
        .rdata_b (rf_b),
        .we      (wb_bus.valid),
        .waddr   (wb_bus.uop.rd),
        .wdata   (wb_bus.result)
    );

    hazard_detect hazard_i (
        .dec_valid (dec_valid),
        .dec_uop   (dec_uop),
        .ex_bus    (ex_bus.monitor),
        .mem_bus   (mem_bus.monitor),
        .wb_bus    (wb_bus.monitor),
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .sel_a     (sel_a),
        .sel_b     (sel_b)
    );

    operand_forward fwd_i (
        .sel_a   (sel_a),
        .sel_b   (sel_b),
        .rf_a    (rf_a),
        .rf_b    (rf_b),
        .mem_bus (mem_bus.monitor),
        .wb_bus  (wb_bus.monitor),
        .op_a    (op_a),
        .op_b    (op_b)
    );

    issue_stage issue_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_uop    (in_uop),
        .in_ready  (in_ready),
        .stall     (stall),
        .dec_valid (dec_valid),
        .dec_uop   (dec_uop),
        .op_a      (op_a),
        .op_b      (op_b),
        .ex_bus    (ex_bus.producer)
    );

    exec_pipe #(
        .DMEM_WORDS (DMEM_WORDS)
    ) exec_i (
        .clk     (clk),
        .rst     (rst),
        .ex_bus  (ex_bus.consumer),
        .mem_bus (mem_bus.producer),
        .wb_bus  (wb_bus.producer)
    );

    assign wb_valid = wb_bus.valid;
    assign wb_rd    = wb_bus.uop.rd;
    assign wb_data  = wb_bus.result;

endmodule

`default_nettype wire

/* exec_pipe.sv */
`default_nettype none

module exec_pipe #(
    parameter int DMEM_WORDS = 16
) (
    input  wire logic clk,
    input  wire logic rst,
    stage_if.consumer ex_bus,
    stage_if.producer mem_bus,
    stage_if.producer wb_bus
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [rv_pkg::XLEN-1:0] alu_out;
    logic                    mem_valid_q;
    rv_pkg::uop_t            mem_uop_q;
    logic [rv_pkg::XLEN-1:0] mem_alu_q;
    logic [IDX_W-1:0]        mem_idx;
    logic [rv_pkg::XLEN-1:0] mem_final;
    logic                    wb_valid_q;
    rv_pkg::uop_t            wb_uop_q;
    logic [rv_pkg::XLEN-1:0] wb_result_q;
    logic [rv_pkg::XLEN-1:0] dmem [DMEM_WORDS];

    // Loads use the adder for their address as well
    always_comb begin
        case (ex_bus.uop.op)
            rv_pkg::OP_SUB: alu_out = ex_bus.op_a - ex_bus.op_b;
            default:        alu_out = ex_bus.op_a + ex_bus.op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid_q <= 1'b0;
            wb_valid_q  <= 1'b0;
        end else begin
            mem_valid_q <= ex_bus.valid;
            wb_valid_q  <= mem_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        mem_uop_q   <= ex_bus.uop;
        mem_alu_q   <= alu_out;
        wb_uop_q    <= mem_uop_q;
        wb_result_q <= mem_final;
    end

    // Word i holds the byte value i in every lane
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= {8{8'(i)}};
            end
        end
    end

    // Word index wraps modulo the memory depth
    assign mem_idx   = mem_alu_q[3 +: IDX_W];
    assign mem_final = (mem_uop_q.op == rv_pkg::OP_LOAD) ? dmem[mem_idx] : mem_alu_q;

    assign mem_bus.valid  = mem_valid_q;
    assign mem_bus.uop    = mem_uop_q;
    assign mem_bus.op_a   = '0;
    assign mem_bus.op_b   = '0;
    assign mem_bus.result = mem_final;

    assign wb_bus.valid  = wb_valid_q;
    assign wb_bus.uop    = wb_uop_q;
    assign wb_bus.op_a   = '0;
    assign wb_bus.op_b   = '0;
    assign wb_bus.result = wb_result_q;

endmodule

`default_nettype wire

/* issue_stage.sv */
`default_nettype none

module issue_stage (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    in_valid,
    input  wire rv_pkg::uop_t            in_uop,
    output      logic                    in_ready,
    input  wire logic                    stall,
    output      logic                    dec_valid,
    output      rv_pkg::uop_t            dec_uop,
    input  wire logic [rv_pkg::XLEN-1:0] op_a,
    input  wire logic [rv_pkg::XLEN-1:0] op_b,
    stage_if.producer                    ex_bus
);

    logic                    dec_valid_q;
    rv_pkg::uop_t            dec_uop_q;
    logic                    advance;
    logic                    ex_valid_q;
    rv_pkg::uop_t            ex_uop_q;
    logic [rv_pkg::XLEN-1:0] ex_op_a_q;
    logic [rv_pkg::XLEN-1:0] ex_op_b_q;
    logic [rv_pkg::XLEN-1:0] op_b_eff;

    assign advance  = dec_valid_q && !stall;
    assign in_ready = !dec_valid_q || !stall;

    assign op_b_eff = rv_pkg::uses_rs2(dec_uop_q.op) ? op_b : rv_pkg::sext_imm(dec_uop_q.imm);

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_q <= 1'b0;
        end else if (in_ready) begin
            dec_valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec_uop_q <= in_uop;
        end
    end

    // A stalled cycle sends a bubble into EX
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= advance;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_uop_q  <= dec_uop_q;
            ex_op_a_q <= op_a;
            ex_op_b_q <= op_b_eff;
        end
    end

    assign dec_valid = dec_valid_q;
    assign dec_uop   = dec_uop_q;

    assign ex_bus.valid  = ex_valid_q;
    assign ex_bus.uop    = ex_uop_q;
    assign ex_bus.op_a   = ex_op_a_q;
    assign ex_bus.op_b   = ex_op_b_q;
    assign ex_bus.result = '0;

    in_uop_held: assert property (
        @(posedge clk) disable iff (rst)
        (in_valid && !in_ready) |=> (!in_valid || $stable(in_uop))
    );

endmodule

`default_nettype wire

/* operand_forward.sv */
`default_nettype none

module operand_forward (
    input  wire rv_pkg::fwd_sel_e        sel_a,
    input  wire rv_pkg::fwd_sel_e        sel_b,
    input  wire logic [rv_pkg::XLEN-1:0] rf_a,
    input  wire logic [rv_pkg::XLEN-1:0] rf_b,
    stage_if.monitor                     mem_bus,
    stage_if.monitor                     wb_bus,
    output      logic [rv_pkg::XLEN-1:0] op_a,
    output      logic [rv_pkg::XLEN-1:0] op_b
);

    always_comb begin
        case (sel_a)
            rv_pkg::FWD_MEM: op_a = mem_bus.result;
            rv_pkg::FWD_WB:  op_a = wb_bus.result;
            default:         op_a = rf_a;
        endcase
    end

    // For addi and load this value is replaced by the immediate in decode
    always_comb begin
        case (sel_b)
            rv_pkg::FWD_MEM: op_b = mem_bus.result;
            rv_pkg::FWD_WB:  op_b = wb_bus.result;
            default:         op_b = rf_b;
        endcase
    end

endmodule

`default_nettype wire

/* hazard_detect.sv */
`default_nettype none

module hazard_detect (
    input  wire logic             dec_valid,
    input  wire rv_pkg::uop_t     dec_uop,
    stage_if.monitor              ex_bus,
    stage_if.monitor              mem_bus,
    stage_if.monitor              wb_bus,
    input  wire logic             clk,
    input  wire logic             rst,
    output      logic             stall,
    output      rv_pkg::fwd_sel_e sel_a,
    output      rv_pkg::fwd_sel_e sel_b
);

    logic use_a;
    logic use_b;
    logic ex_hit_a;
    logic ex_hit_b;
    logic mem_hit_a;
    logic mem_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;

    // Neither x0 nor an empty decode carries a dependency
    assign use_a = dec_valid && (dec_uop.rs1 != '0);
    assign use_b = dec_valid && rv_pkg::uses_rs2(dec_uop.op) && (dec_uop.rs2 != '0);

    assign ex_hit_a  = use_a && ex_bus.valid  && (ex_bus.uop.rd  == dec_uop.rs1);
    assign ex_hit_b  = use_b && ex_bus.valid  && (ex_bus.uop.rd  == dec_uop.rs2);
    assign mem_hit_a = use_a && mem_bus.valid && (mem_bus.uop.rd == dec_uop.rs1);
    assign mem_hit_b = use_b && mem_bus.valid && (mem_bus.uop.rd == dec_uop.rs2);
    assign wb_hit_a  = use_a && wb_bus.valid  && (wb_bus.uop.rd  == dec_uop.rs1);
    assign wb_hit_b  = use_b && wb_bus.valid  && (wb_bus.uop.rd  == dec_uop.rs2);

    // A producer still in EX has no registered result yet, so decode waits one cycle
    // until it reaches MEM where the value (or the loaded word) can be forwarded
    assign stall = ex_hit_a || ex_hit_b;

    always_comb begin
        if (mem_hit_a) begin
            sel_a = rv_pkg::FWD_MEM;
        end else if (wb_hit_a) begin
            sel_a = rv_pkg::FWD_WB;
        end else begin
            sel_a = rv_pkg::FWD_RF;
        end

        if (mem_hit_b) begin
            sel_b = rv_pkg::FWD_MEM;
        end else if (wb_hit_b) begin
            sel_b = rv_pkg::FWD_WB;
        end else begin
            sel_b = rv_pkg::FWD_RF;
        end
    end

    stall_needs_decode: assert property (
        @(posedge clk) disable iff (rst) stall |-> dec_valid
    );

    // The bubble inserted by a stall clears the EX match on the next cycle
    stall_one_cycle: assert property (
        @(posedge clk) disable iff (rst) stall |=> !stall
    );

endmodule

`default_nettype wire

/* reg_file.sv */
`default_nettype none

module reg_file (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [rv_pkg::REG_ADDR_WIDTH-1:0] raddr_a,
    input  wire logic [rv_pkg::REG_ADDR_WIDTH-1:0] raddr_b,
    output      logic [rv_pkg::XLEN-1:0]           rdata_a,
    output      logic [rv_pkg::XLEN-1:0]           rdata_b,
    input  wire logic                              we,
    input  wire logic [rv_pkg::REG_ADDR_WIDTH-1:0] waddr,
    input  wire logic [rv_pkg::XLEN-1:0]           wdata
);

    logic [rv_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Reads are asynchronous and a write lands at the edge
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    // x0 is cleared at reset and the write port must never touch it
    x0_reads_zero: assert property (
        @(posedge clk) disable iff (rst)
        ((raddr_a != '0) || (rdata_a == '0)) && ((raddr_b != '0) || (rdata_b == '0))
    );

endmodule

`default_nettype wire

/* stage_if.sv */
`default_nettype none

interface stage_if;

    logic                   valid;
    rv_pkg::uop_t           uop;
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] result;

    modport producer (output valid, uop, op_a, op_b, result);

    modport consumer (input valid, uop, op_a, op_b, result);

    // Hazard and forwarding logic only look at who writes what
    modport monitor (input valid, uop, result);

endinterface

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN = 64;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int IMM_WIDTH = 12;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_ADDI,
        OP_LOAD
    } op_e;

    typedef struct packed {
        op_e                        op;
        logic [REG_ADDR_WIDTH-1:0]  rd;
        logic [REG_ADDR_WIDTH-1:0]  rs1;
        logic [REG_ADDR_WIDTH-1:0]  rs2;
        logic signed [IMM_WIDTH-1:0] imm;
    } uop_t;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // Only the register-register forms read rs2
    function automatic logic uses_rs2(input op_e op);
        return (op == OP_ADD) || (op == OP_SUB);
    endfunction

    function automatic logic [XLEN-1:0] sext_imm(input logic signed [IMM_WIDTH-1:0] imm);
        return {{(XLEN-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
    endfunction

endpackage

`default_nettype wire
